//--- hdl/barrel_core.sv
//------------------------------
// Barrel core top
// Scheduler, register files, operand
// fetch, 16 lanes and writeback
//------------------------------
`timescale 1ns/1ps

module barrel_core import barrel_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [STRANDS-1:0]   instr_valid,
	input  instr_t [STRANDS-1:0] instr_word,
	output logic [STRANDS-1:0]   instr_ack,
	output logic                 wb_valid,
	output strand_t              wb_strand,
	output reg_idx_t             wb_reg,
	output logic                 wb_is_vector,
	output vector_t              wb_value
);

	logic     iss_valid;
	strand_t  iss_strand;
	instr_t   iss_instr;
	strand_t  rd_strand;
	reg_idx_t scalar_sel1;
	reg_idx_t scalar_sel2;
	reg_idx_t vector_sel1;
	reg_idx_t vector_sel2;
	word_t    scalar_value1;
	word_t    scalar_value2;
	vector_t  vector_value1;
	vector_t  vector_value2;
	vector_t  lane_result;	// One word per lane

	lane_bus_if  lbus ();
	writeback_if wbus ();

	strand_scheduler strand_scheduler_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_word  (instr_word),
		.instr_ack   (instr_ack),
		.iss_valid   (iss_valid),
		.iss_strand  (iss_strand),
		.iss_instr   (iss_instr)
	);

	register_files register_files_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.rd_strand     (rd_strand),
		.scalar_sel1   (scalar_sel1),
		.scalar_sel2   (scalar_sel2),
		.vector_sel1   (vector_sel1),
		.vector_sel2   (vector_sel2),
		.wb            (wbus),
		.scalar_value1 (scalar_value1),
		.scalar_value2 (scalar_value2),
		.vector_value1 (vector_value1),
		.vector_value2 (vector_value2)
	);

	operand_fetch operand_fetch_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.iss_valid     (iss_valid),
		.iss_strand    (iss_strand),
		.iss_instr     (iss_instr),
		.scalar_value1 (scalar_value1),
		.scalar_value2 (scalar_value2),
		.vector_value1 (vector_value1),
		.vector_value2 (vector_value2),
		.scalar_sel1   (scalar_sel1),
		.scalar_sel2   (scalar_sel2),
		.vector_sel1   (vector_sel1),
		.vector_sel2   (vector_sel2),
		.rd_strand     (rd_strand),
		.lanes         (lbus)
	);

	for (genvar g = 0; g < LANES; g++)
	begin : gen_lane
		vector_lane #(.LANE(g)) vector_lane_i (
			.clk    (clk),
			.rst_n  (rst_n),
			.lane   (lbus),
			.result (lane_result[g])
		);
	end

	writeback_stage writeback_stage_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.lanes       (lbus),
		.lane_result (lane_result),
		.wb          (wbus)
	);

	// Commit also shows at the top level
	assign wb_valid     = wbus.valid;
	assign wb_strand    = wbus.strand;
	assign wb_reg       = wbus.dest;
	assign wb_is_vector = wbus.is_vector;
	assign wb_value     = wbus.value;

endmodule

//--- hdl/barrel_pkg.sv
//------------------------------
// Barrel pipeline package
// Sizes, ALU opcodes, operand modes
// and the two instruction formats
//------------------------------
package barrel_pkg;

	localparam int STRANDS   = 4;	// Hardware strands
	localparam int LANES     = 16;	// Vector lanes, 32 bits each
	localparam int REGS      = 32;	// Registers per strand per file
	localparam int ISSUE_GAP = 4;	// Min cycles between two issues of one strand
	localparam int COOL_W    = $clog2(ISSUE_GAP);	// Cooldown counter width

	typedef logic [$clog2(STRANDS)-1:0] strand_t;
	typedef logic [$clog2(REGS)-1:0]    reg_idx_t;
	typedef logic [31:0]                word_t;
	typedef word_t [LANES-1:0]          vector_t;	// Word 0 in the low bits
	typedef logic [3:0]                 op_t;
	typedef logic [1:0]                 vmode_t;

	localparam op_t OP_ADD = 4'd0;
	localparam op_t OP_SUB = 4'd1;
	localparam op_t OP_AND = 4'd2;
	localparam op_t OP_OR  = 4'd3;
	localparam op_t OP_XOR = 4'd4;
	localparam op_t OP_SHL = 4'd5;	// By b[4:0]
	localparam op_t OP_SHR = 4'd6;	// Logical, by b[4:0]
	localparam op_t OP_SLT = 4'd7;	// Unsigned compare
	localparam op_t OP_MOV = 4'd8;	// Passes b

	localparam vmode_t MODE_SS = 2'd0;	// Scalar op scalar
	localparam vmode_t MODE_VS = 2'd1;	// Vector op broadcast scalar
	localparam vmode_t MODE_VV = 2'd2;	// Vector op vector, VS in imm format
	localparam vmode_t MODE_SV = 2'd3;	// Broadcast scalar op vector

	localparam logic FMT_REG = 1'b0;
	localparam logic FMT_IMM = 1'b1;

	typedef struct packed {
		logic       fmt;
		op_t        op;
		vmode_t     mode;
		reg_idx_t   dest;
		reg_idx_t   src1;
		reg_idx_t   src2;
		logic [9:0] unused;
	} reg_fmt_t;

	typedef struct packed {
		logic        fmt;
		op_t         op;
		vmode_t      mode;
		reg_idx_t    dest;
		reg_idx_t    src1;
		logic [14:0] imm;	// Zero-extended
	} imm_fmt_t;

	// Same word seen as either format, fmt bit picks which one applies
	typedef union packed {
		reg_fmt_t r;
		imm_fmt_t i;
	} instr_t;

endpackage

//--- hdl/lane_bus_if.sv
//------------------------------
// Lane bus
// Decoded operands and controls from
// operand fetch to lanes and writeback
//------------------------------
`timescale 1ns/1ps

interface lane_bus_if import barrel_pkg::*; ();

	logic     valid;
	op_t      op;
	strand_t  strand;
	reg_idx_t dest;
	logic     is_vector;
	vector_t  a;	// Per-lane operand a
	vector_t  b;	// Per-lane operand b

	modport fetch   (output valid, op, strand, dest, is_vector, a, b);
	modport lane    (input valid, op, a, b);
	modport collect (input valid, strand, dest, is_vector);

endinterface

//--- hdl/operand_fetch.sv
//------------------------------
// Operand fetch
// Decodes the issued word and forms
// per-lane a/b operands by mode
//------------------------------
`timescale 1ns/1ps

module operand_fetch import barrel_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      iss_valid,
	input  strand_t   iss_strand,
	input  instr_t    iss_instr,
	input  word_t     scalar_value1,
	input  word_t     scalar_value2,
	input  vector_t   vector_value1,
	input  vector_t   vector_value2,
	output reg_idx_t  scalar_sel1,
	output reg_idx_t  scalar_sel2,
	output reg_idx_t  vector_sel1,
	output reg_idx_t  vector_sel2,
	output strand_t   rd_strand,
	lane_bus_if.fetch lanes
);

	logic     d_valid;
	strand_t  d_strand;
	op_t      d_op;
	vmode_t   d_mode;
	reg_idx_t d_dest;
	logic     d_fmt;
	word_t    d_imm;
	logic     a_is_vector;	// a from vector file
	logic     b_is_vector;	// Reg-format b from vector file
	vector_t  opa;
	vector_t  opb;

	// Register selects straight from the issued word
	assign rd_strand   = iss_strand;
	assign scalar_sel1 = iss_instr.r.src1;
	assign scalar_sel2 = iss_instr.r.src2;
	assign vector_sel1 = iss_instr.r.src1;
	assign vector_sel2 = iss_instr.r.src2;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			d_valid <= 1'b0;
		else
			d_valid <= iss_valid;
	end

	// Decoded fields, aligned with register file reads
	always_ff @(posedge clk)
	begin
		d_strand <= iss_strand;
		d_op     <= iss_instr.r.op;
		d_mode   <= iss_instr.r.mode;
		d_dest   <= iss_instr.r.dest;
		d_fmt    <= iss_instr.r.fmt;
		d_imm    <= word_t'(iss_instr.i.imm);	// Zero-extend
	end

	assign a_is_vector = (d_mode == MODE_VS) || (d_mode == MODE_VV);
	assign b_is_vector = (d_mode == MODE_VV) || (d_mode == MODE_SV);

	always_comb
	begin
		for (int l = 0; l < LANES; l++)
		begin
			opa[l] = a_is_vector ? vector_value1[l] : scalar_value1;	// Else broadcast
			if (d_fmt == FMT_IMM)
				opb[l] = d_imm;	// Imm always lands on b
			else if (b_is_vector)
				opb[l] = vector_value2[l];
			else
				opb[l] = scalar_value2;
		end
	end

	assign lanes.valid     = d_valid;
	assign lanes.op        = d_op;
	assign lanes.strand    = d_strand;
	assign lanes.dest      = d_dest;
	assign lanes.is_vector = (d_mode != MODE_SS);
	assign lanes.a         = opa;
	assign lanes.b         = opb;

endmodule

//--- hdl/register_files.sv
//------------------------------
// Register files
// Per-strand scalar and vector regs,
// two registered reads per file
//------------------------------
`timescale 1ns/1ps

module register_files import barrel_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  strand_t   rd_strand,
	input  reg_idx_t  scalar_sel1,
	input  reg_idx_t  scalar_sel2,
	input  reg_idx_t  vector_sel1,
	input  reg_idx_t  vector_sel2,
	writeback_if.sink wb,
	output word_t     scalar_value1,
	output word_t     scalar_value2,
	output vector_t   vector_value1,
	output vector_t   vector_value2
);

	word_t   scalar_mem [STRANDS][REGS];
	vector_t vector_mem [STRANDS][REGS];

	// Scalar file
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < STRANDS; s++)
				for (int r = 0; r < REGS; r++)
					scalar_mem[s][r] <= '0;
			scalar_value1 <= '0;
			scalar_value2 <= '0;
		end
		else
		begin
			scalar_value1 <= scalar_mem[rd_strand][scalar_sel1];	// Old value on same-edge write
			scalar_value2 <= scalar_mem[rd_strand][scalar_sel2];
			if (wb.valid && !wb.is_vector)
				scalar_mem[wb.strand][wb.dest] <= wb.value[0];	// Lane 0 only
		end
	end

	// Vector file
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < STRANDS; s++)
				for (int r = 0; r < REGS; r++)
					vector_mem[s][r] <= '0;
			vector_value1 <= '0;
			vector_value2 <= '0;
		end
		else
		begin
			vector_value1 <= vector_mem[rd_strand][vector_sel1];
			vector_value2 <= vector_mem[rd_strand][vector_sel2];
			if (wb.valid && wb.is_vector)
				vector_mem[wb.strand][wb.dest] <= wb.value;	// Full width, no mask
		end
	end

endmodule

//--- hdl/strand_scheduler.sv
//------------------------------
// Strand scheduler
// Round-robin issue over strands with
// a per-strand cooldown between issues
//------------------------------
`timescale 1ns/1ps

module strand_scheduler import barrel_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [STRANDS-1:0]   instr_valid,
	input  instr_t [STRANDS-1:0] instr_word,
	output logic [STRANDS-1:0]   instr_ack,
	output logic                 iss_valid,
	output strand_t              iss_strand,
	output instr_t               iss_instr
);

	strand_t             last_grant;	// Round-robin pointer
	logic [COOL_W-1:0]   cooldown [STRANDS];	// Cycles until strand may issue again
	logic [STRANDS-1:0]  eligible;
	logic                grant_hit;
	strand_t             grant_id;

	always_comb
	begin
		for (int s = 0; s < STRANDS; s++)
			eligible[s] = instr_valid[s] && (cooldown[s] == '0);
	end

	// Search upward from pointer+1, wrapping around
	always_comb
	begin
		strand_t cand;
		grant_hit = 1'b0;
		grant_id  = last_grant;
		cand      = last_grant;
		for (int k = 1; k <= STRANDS; k++)
		begin
			cand = strand_t'((int'(last_grant) + k) % STRANDS);
			if (!grant_hit && eligible[cand])
			begin
				grant_hit = 1'b1;
				grant_id  = cand;
			end
		end
	end

	always_comb
	begin
		instr_ack = '0;
		if (grant_hit)
			instr_ack[grant_id] = 1'b1;	// One-cycle pulse
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_grant <= strand_t'(STRANDS - 1);	// First search starts at strand 0
			iss_valid  <= 1'b0;
			for (int s = 0; s < STRANDS; s++)
				cooldown[s] <= '0;
		end
		else
		begin
			iss_valid <= grant_hit;
			if (grant_hit)
				last_grant <= grant_id;
			for (int s = 0; s < STRANDS; s++)
			begin
				if (instr_ack[s])
					cooldown[s] <= COOL_W'(ISSUE_GAP - 1);	// Blocks next ISSUE_GAP-1 cycles
				else if (cooldown[s] != '0)
					cooldown[s] <= cooldown[s] - 1'b1;
			end
		end
	end

	// Issued instruction for the decode cycle
	always_ff @(posedge clk)
	begin
		iss_strand <= grant_id;
		iss_instr  <= instr_word[grant_id];
	end

endmodule

//--- hdl/vector_lane.sv
//------------------------------
// Vector lane
// One 32-bit ALU, registered result
//------------------------------
`timescale 1ns/1ps

module vector_lane import barrel_pkg::*;
#(
	parameter int LANE = 0
)
(
	input  logic     clk,
	input  logic     rst_n,
	lane_bus_if.lane lane,
	output word_t    result
);

	word_t a;
	word_t b;
	word_t alu_out;

	assign a = lane.a[LANE];	// This lane's operands
	assign b = lane.b[LANE];

	always_comb
	begin
		case (lane.op)
			OP_ADD:  alu_out = a + b;
			OP_SUB:  alu_out = a - b;
			OP_AND:  alu_out = a & b;
			OP_OR:   alu_out = a | b;
			OP_XOR:  alu_out = a ^ b;
			OP_SHL:  alu_out = a << b[4:0];
			OP_SHR:  alu_out = a >> b[4:0];
			OP_SLT:  alu_out = word_t'(a < b);	// Unsigned
			OP_MOV:  alu_out = b;
			default: alu_out = '0;	// Undefined codes
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			result <= '0;
		else if (lane.valid)
			result <= alu_out;	// Held while idle
	end

endmodule

//--- hdl/writeback_if.sv
//------------------------------
// Writeback bus
// Committed result to register files
//------------------------------
`timescale 1ns/1ps

interface writeback_if import barrel_pkg::*; ();

	logic     valid;
	strand_t  strand;
	reg_idx_t dest;
	logic     is_vector;
	vector_t  value;	// Scalar result in word 0

	modport source (output valid, strand, dest, is_vector, value);
	modport sink   (input valid, strand, dest, is_vector, value);

endinterface

//--- hdl/writeback_stage.sv
//------------------------------
// Writeback stage
// Lines controls up with lane results
// and drives the commit
//------------------------------
`timescale 1ns/1ps

module writeback_stage import barrel_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	lane_bus_if.collect lanes,
	input  vector_t     lane_result,
	writeback_if.source wb
);

	logic     q_valid;
	strand_t  q_strand;
	reg_idx_t q_dest;
	logic     q_is_vector;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			q_valid <= 1'b0;
		else
			q_valid <= lanes.valid;
	end

	// Same edge as the lane result registers
	always_ff @(posedge clk)
	begin
		q_strand    <= lanes.strand;
		q_dest      <= lanes.dest;
		q_is_vector <= lanes.is_vector;
	end

	always_comb
	begin
		wb.value = '0;
		if (q_is_vector)
			wb.value = lane_result;
		else
			wb.value[0] = lane_result[0];	// Scalar, upper words stay zero
	end

	assign wb.valid     = q_valid;
	assign wb.strand    = q_strand;
	assign wb.dest      = q_dest;
	assign wb.is_vector = q_is_vector;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the barrel core simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module barrel_core_tb -f vlog.f -o barrel_sim \
	&& ./obj_dir/barrel_sim > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -qxF '** PASS **' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/barrel_core_tb.sv
//------------------------------
// Barrel core testbench
// Random strand traffic, reference model
// of scheduler, registers and ALU
//------------------------------
`timescale 1ns/1ps

module barrel_core_tb import barrel_pkg::*;
();

	localparam int NUM_INSTR       = 400;	// Instructions raised in total
	localparam int WATCHDOG_CYCLES = NUM_INSTR * ISSUE_GAP * STRANDS + 200;

	typedef struct {
		int       due;	// Cycle in which wb_valid is expected
		strand_t  strand;
		reg_idx_t dest;
		logic     is_vector;
		vector_t  value;
	} commit_t;

	logic                 clk;
	logic                 rst_n;
	logic [STRANDS-1:0]   instr_valid;
	instr_t [STRANDS-1:0] instr_word;
	logic [STRANDS-1:0]   instr_ack;
	logic                 wb_valid;
	strand_t              wb_strand;
	reg_idx_t             wb_reg;
	logic                 wb_is_vector;
	vector_t              wb_value;

	word_t              model_scalar [STRANDS][REGS];
	vector_t            model_vector [STRANDS][REGS];
	commit_t            expected_q [$];	// Commits in flight in issue order
	int                 last_ack [STRANDS];	// Cycle of each strand's last grant
	int                 rr_ptr;	// Model round-robin pointer
	int                 cyc;
	int                 raised;
	int                 acked;
	int                 mismatch_count;
	int                 other_count;
	logic [STRANDS-1:0] acked_prev;	// Grants taken at the last edge

	tb_clock_gen clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	barrel_core barrel_core_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr_word   (instr_word),
		.instr_ack    (instr_ack),
		.wb_valid     (wb_valid),
		.wb_strand    (wb_strand),
		.wb_reg       (wb_reg),
		.wb_is_vector (wb_is_vector),
		.wb_value     (wb_value)
	);

	task automatic compare_word(input string name, input word_t expected,
		input word_t actual);
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("MISMATCH at %0d ns: %s expected %h actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_vector(input string name, input vector_t expected,
		input vector_t actual);
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("MISMATCH at %0d ns: %s expected %h actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_strand(input string name, input strand_t expected,
		input strand_t actual);
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("MISMATCH at %0d ns: %s expected %0d actual %0d",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_reg(input string name, input reg_idx_t expected,
		input reg_idx_t actual);
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("MISMATCH at %0d ns: %s expected %0d actual %0d",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_flag(input string name, input logic expected,
		input logic actual);
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("MISMATCH at %0d ns: %s expected %b actual %b",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_ack(input string name, input logic [STRANDS-1:0] expected,
		input logic [STRANDS-1:0] actual);
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("MISMATCH at %0d ns: %s expected %b actual %b",
				$time, name, expected, actual);
		end
	endtask

	task automatic report_error(input string msg);
		other_count++;
		$display("ERROR at %0d ns: %s", $time, msg);
	endtask

	// ALU rules from the op table
	function automatic word_t alu_model(input op_t op, input word_t a, input word_t b);
		word_t r;
		case (op)
			OP_ADD:  r = a + b;
			OP_SUB:  r = a + ~b + 32'd1;	// Two's complement
			OP_AND:  r = a & b;
			OP_OR:   r = a | b;
			OP_XOR:  r = (a | b) & ~(a & b);
			OP_SHL:  r = a << b[4:0];
			OP_SHR:  r = a >> b[4:0];
			OP_SLT:  r = (a < b) ? 32'd1 : 32'd0;	// Unsigned
			OP_MOV:  r = b;
			default: r = '0;	// Undefined codes
		endcase
		return r;
	endfunction

	// Random word of any op, mode and format
	function automatic instr_t random_instr();
		instr_t w;
		w        = instr_t'($urandom);
		w.r.dest = reg_idx_t'($urandom % 8);	// Small range so reads hit earlier writes
		w.r.src1 = reg_idx_t'($urandom % 8);
		if (w.r.fmt == FMT_REG)
			w.r.src2 = reg_idx_t'($urandom % 8);	// Imm keeps full random range
		return w;
	endfunction

	// Executes one granted instruction and queues its commit
	task automatic apply_model(input strand_t s, input instr_t w);
		commit_t c;
		word_t   a;
		word_t   b;
		word_t   lane0;
		vmode_t  mode;
		mode        = w.r.mode;
		c.due       = cyc + 3;
		c.strand    = s;
		c.dest      = w.r.dest;
		c.is_vector = (mode != MODE_SS);
		c.value     = '0;
		for (int l = 0; l < LANES; l++)
		begin
			if (mode == MODE_SS || mode == MODE_SV)
				a = model_scalar[s][w.r.src1];	// Scalar a for SS and SV
			else
				a = model_vector[s][w.r.src1][l];
			if (w.r.fmt == FMT_IMM)
				b = word_t'(w.i.imm);	// VV acts as VS here
			else if (mode == MODE_VV || mode == MODE_SV)
				b = model_vector[s][w.r.src2][l];
			else
				b = model_scalar[s][w.r.src2];
			c.value[l] = alu_model(w.r.op, a, b);
		end
		if (c.is_vector)
			model_vector[s][c.dest] = c.value;
		else
		begin
			lane0      = c.value[0];
			c.value    = '0;
			c.value[0] = lane0;	// Upper words zero
			model_scalar[s][c.dest] = lane0;
		end
		expected_q.push_back(c);
	endtask

	task automatic check_commit();
		commit_t c;
		if (expected_q.size() > 0 && expected_q[0].due == cyc)
		begin
			c = expected_q.pop_front();
			compare_flag("wb_valid", 1'b1, wb_valid);
			compare_strand("wb_strand", c.strand, wb_strand);
			compare_reg("wb_reg", c.dest, wb_reg);
			compare_flag("wb_is_vector", c.is_vector, wb_is_vector);
			if (c.is_vector)
				compare_vector("wb_value", c.value, wb_value);
			else
			begin
				for (int l = 0; l < LANES; l++)
					compare_word($sformatf("wb_value[%0d]", l), c.value[l], wb_value[l]);
			end
		end
		else
			compare_flag("wb_valid", 1'b0, wb_valid);	// No commit due
	endtask

	task automatic drive_inputs();
		for (int s = 0; s < STRANDS; s++)
		begin
			if (acked_prev[s])
				instr_valid[s] = 1'b0;	// Taken at the last edge
			if (!instr_valid[s] && raised < NUM_INSTR && ($urandom % 10) < 6)
			begin
				instr_valid[s] = 1'b1;
				instr_word[s]  = random_instr();
				raised++;
			end
		end
	endtask

	// Model of the round-robin grant with per-strand cooldown
	task automatic check_schedule();
		logic [STRANDS-1:0] exp_ack;
		strand_t            sid;
		logic               found;
		exp_ack = '0;
		found   = 1'b0;
		sid     = '0;
		for (int k = 1; k <= STRANDS; k++)
		begin
			if (!found && instr_valid[(rr_ptr + k) % STRANDS]
				&& (cyc - last_ack[(rr_ptr + k) % STRANDS] >= ISSUE_GAP))
			begin
				found = 1'b1;
				sid   = strand_t'((rr_ptr + k) % STRANDS);
			end
		end
		if ((instr_ack & ~instr_valid) != '0)
			report_error("acknowledge given to a strand with no valid instruction");
		if ($countones(instr_ack) > 1)
			report_error("more than one acknowledge in one cycle");
		for (int s = 0; s < STRANDS; s++)
			if (instr_ack[s] && (cyc - last_ack[s] < ISSUE_GAP))
				report_error($sformatf("strand %0d acknowledged again within the issue gap", s));
		if (found)
			exp_ack[sid] = 1'b1;
		compare_ack("instr_ack", exp_ack, instr_ack);
		acked_prev = exp_ack;
		if (found)
		begin
			apply_model(sid, instr_word[sid]);
			last_ack[sid] = cyc;
			rr_ptr        = int'(sid);
			acked++;
		end
	endtask

	task automatic run_cycle();
		@(negedge clk);
		cyc++;
		check_commit();	// Commit due this cycle
		drive_inputs();
		#1;
		check_schedule();	// Grant for the inputs just driven
	endtask

	initial
	begin
		instr_valid    = '0;
		instr_word     = '0;
		acked_prev     = '0;
		rr_ptr         = STRANDS - 1;
		cyc            = 0;
		raised         = 0;
		acked          = 0;
		mismatch_count = 0;
		other_count    = 0;
		for (int s = 0; s < STRANDS; s++)
		begin
			last_ack[s] = -1000;
			for (int r = 0; r < REGS; r++)
			begin
				model_scalar[s][r] = '0;
				model_vector[s][r] = '0;
			end
		end
		void'($urandom(32'hd1d4));
		do
		begin
			@(negedge clk);
			if (instr_ack !== '0 || wb_valid !== 1'b0)
				report_error("instr_ack or wb_valid high during or right after reset");
		end
		while (rst_n !== 1'b1);
		while (acked < NUM_INSTR || expected_q.size() > 0)
			run_cycle();
		repeat (8)
			run_cycle();	// Idle tail catches stray commits
		$display("Errors: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- verif/tb_clock_gen.sv
//------------------------------
// Testbench clock and reset
// 10 ns clock, reset low 8 cycles
//------------------------------
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;	// Flops still see reset at this edge
	end

endmodule

//--- vlog.f
hdl/barrel_pkg.sv
hdl/lane_bus_if.sv
hdl/writeback_if.sv
hdl/strand_scheduler.sv
hdl/register_files.sv
hdl/operand_fetch.sv
hdl/vector_lane.sv
hdl/writeback_stage.sv
hdl/barrel_core.sv
verif/tb_clock_gen.sv
verif/barrel_core_tb.sv
